/* hdl/heap_alloc.sv */
//########################################
// heap allocator
//  top-of-heap and LIFO free-list
//  free-list links kept in freed cells
//  ram port steering per opcode
//  block ram instance
//########################################

`timescale 1ns/1ps

`include "heap_config.svh"

module heap_alloc
    import word_pkg::*;
    import heap_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_reset,
    input  heap_op_e    i_op,               // already validated
    input  ptr_req_t    i_ptr,
    input  mem_req_t    i_mem,
    output word_t       o_addr,             // UNDEF unless an alloc last cycle
    output word_t       o_rdata,            // ram read data
    output logic        o_exhausted         // no fresh cell and empty list
);

    word_t                  top;            // next fresh cell
    word_t                  head;           // free-list head, NIL when empty
    word_t                  head_link;      // link held in the head cell
    logic                   link_pend;      // head link is on the ram output now
    logic [`ADDR_SZ-1:0]    free_cnt;       // cells on the free-list
    word_t                  ram_rdata;
    word_t                  eff_link;       // link of the current head
    word_t                  alloc_addr;     // cell an alloc alone would return
    logic                   list_empty;
    logic                   pop;            // alloc served from the free-list
    ram_port_t              wr_port;
    ram_port_t              rd_port;

    assign list_empty  = (head == NIL);
    assign pop         = (i_op == OP_ALLOC) && !list_empty;
    assign eff_link    = link_pend ? ram_rdata : head_link;    // pending bypass
    assign alloc_addr  = list_empty ? top : head;
    assign o_exhausted = list_empty && (top[`ADDR_SZ-1:0] == '1); // 255 fresh cells
    assign o_rdata     = ram_rdata;

    always_comb begin
        wr_port = '0;
        rd_port = '0;
        case (i_op)
            OP_ALLOC: begin
                wr_port.en   = 1'b1;
                wr_port.addr = alloc_addr[`ADDR_SZ-1:0];
                wr_port.data = i_ptr.data;              // initial value
                rd_port.en   = pop && (eff_link != NIL); // fetch link of next head
                rd_port.addr = eff_link[`ADDR_SZ-1:0];
            end
            OP_FREE: begin
                wr_port.en   = 1'b1;
                wr_port.addr = i_ptr.addr[`ADDR_SZ-1:0];
                wr_port.data = head;                    // link to old head
            end
            OP_ALLOC_FREE: begin
                wr_port.en   = 1'b1;
                wr_port.addr = i_ptr.addr[`ADDR_SZ-1:0];
                wr_port.data = i_ptr.data;
            end
            OP_READ: begin
                rd_port.en   = 1'b1;
                rd_port.addr = i_mem.raddr[`ADDR_SZ-1:0];
            end
            OP_WRITE: begin
                wr_port.en   = 1'b1;
                wr_port.addr = i_mem.waddr[`ADDR_SZ-1:0];
                wr_port.data = i_mem.wdata;
            end
            OP_READ_WRITE: begin
                rd_port.en   = 1'b1;
                rd_port.addr = i_mem.raddr[`ADDR_SZ-1:0];
                wr_port.en   = 1'b1;
                wr_port.addr = i_mem.waddr[`ADDR_SZ-1:0];
                wr_port.data = i_mem.wdata;
            end
            default: ;                                  // idle, dropped error
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            top       <= ADDR_BASE;
            head      <= NIL;
            link_pend <= 1'b0;
            free_cnt  <= '0;
            o_addr    <= UNDEF;
        end else begin
            o_addr    <= UNDEF;
            link_pend <= 1'b0;
            case (i_op)
                OP_ALLOC: begin
                    o_addr <= alloc_addr;
                    if (list_empty) begin
                        top <= top + 1'b1;              // exhaustion guards the wrap
                    end else begin
                        head      <= eff_link;
                        link_pend <= (eff_link != NIL);
                        free_cnt  <= free_cnt - 1'b1;
                    end
                end
                OP_FREE: begin
                    head     <= i_ptr.addr;
                    free_cnt <= free_cnt + 1'b1;
                end
                OP_ALLOC_FREE: begin
                    o_addr <= i_ptr.addr;               // list untouched
                end
                default: ;
            endcase
        end
    end

    // link capture comes first, a memory read next cycle reuses the port
    always_ff @(posedge i_clk) begin
        if (i_op == OP_FREE) begin
            head_link <= head;                          // known without a read
        end else if (link_pend) begin
            head_link <= ram_rdata;
        end
    end

    heap_bram bram0 (
        .i_clk   (i_clk),
        .i_wr    (wr_port),
        .i_rd    (rd_port),
        .o_rdata (ram_rdata)
    );

    a_alloc_tags: assert property (
        @(posedge i_clk) disable iff (i_reset)
        ($past(i_op) == OP_ALLOC) |-> (o_addr[`WORD_SZ-1 -: 4] == ADDR_BASE[`WORD_SZ-1 -: 4])
    ) else $error("heap_alloc: alloc returned untagged address %h", o_addr);

    a_top_no_wrap: assert property (
        @(posedge i_clk) disable iff (i_reset)
        $changed(top) |-> (top[`ADDR_SZ-1:0] != '0)
    ) else $error("heap_alloc: top wrapped");

    a_head_nil: assert property (
        @(posedge i_clk) disable iff (i_reset)
        list_empty == (free_cnt == '0)
    ) else $error("heap_alloc: head %h with %0d free cells", head, free_cnt);

endmodule

/* hdl/heap_bram.sv */
//########################################
// heap block ram
//  one write port, one read port
//  read data registered, 1 cycle
//########################################

`timescale 1ns/1ps

`include "heap_config.svh"

module heap_bram
    import word_pkg::*;
    import heap_pkg::*;
(
    input  logic        i_clk,
    input  ram_port_t   i_wr,               // write request
    input  ram_port_t   i_rd,               // read request, data ignored
    output word_t       o_rdata             // holds until next read
);

    word_t mem [`HEAP_DEPTH];               // no init, cells written before use

    always_ff @(posedge i_clk) begin
        if (i_wr.en) begin
            mem[i_wr.addr] <= i_wr.data;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rd.en) begin
            o_rdata <= mem[i_rd.addr];      // old data on same-address write
        end
    end

    // steering upstream must never hand an unknown index to an enabled port
    a_wr_addr_known: assert property (@(posedge i_clk) i_wr.en |-> !$isunknown(i_wr.addr))
        else $error("heap_bram: X on write address");
    a_rd_addr_known: assert property (@(posedge i_clk) i_rd.en |-> !$isunknown(i_rd.addr))
        else $error("heap_bram: X on read address");

endmodule

/* hdl/heap_config.svh */
//########################################
// heap sizing macros
//  WORD_SZ     bits per tagged word
//  ADDR_SZ     bits of physical address
//  HEAP_DEPTH  number of ram words
//########################################

`ifndef HEAP_CONFIG_SVH
`define HEAP_CONFIG_SVH

// tag layout in word_pkg only works for 16-bit words
`define WORD_SZ     16

`define ADDR_SZ     8                   // low byte of a heap address
`define HEAP_DEPTH  (1 << `ADDR_SZ)     // one block ram

`endif

/* hdl/heap_op_decode.sv */
//########################################
// heap request decoder
//  strobe pattern -> heap_op_e
//  exhausted alloc -> OP_ERROR
//  sticky halt flag, drives o_err
//########################################

`timescale 1ns/1ps

module heap_op_decode
    import word_pkg::*;
    import heap_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_reset,
    input  ptr_req_t    i_ptr,              // pointer port
    input  mem_req_t    i_mem,              // memory port
    input  logic        i_exhausted,        // no cell left for a plain alloc
    output heap_op_e    o_op,               // combinational
    output logic        o_err               // registered halt
);

    logic [3:0] pattern;                    // {alloc, free, rd, wr}
    heap_op_e   op_raw;                     // before the halt override
    logic       halt;

    assign pattern = {i_ptr.alloc, i_ptr.free, i_mem.rd, i_mem.wr};

    always_comb begin
        case (pattern)
            4'b0000: op_raw = OP_IDLE;
            4'b1000: op_raw = i_exhausted ? OP_ERROR : OP_ALLOC;
            4'b0100: op_raw = OP_FREE;
            4'b1100: op_raw = OP_ALLOC_FREE;    // never runs out, cell recycled
            4'b0010: op_raw = OP_READ;
            4'b0001: op_raw = OP_WRITE;
            4'b0011: op_raw = OP_READ_WRITE;
            default: op_raw = OP_ERROR;         // ports mixed in one cycle
        endcase
    end

    // a halted heap ignores everything until reset
    assign o_op = halt ? OP_IDLE : op_raw;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            halt <= 1'b0;
        end else if (op_raw == OP_ERROR) begin
            halt <= 1'b1;                   // sticky
        end
    end

    assign o_err = halt;

    // once raised, the error only clears through a reset cycle
    a_err_sticky: assert property (
        @(posedge i_clk) disable iff (i_reset)
        $fell(o_err) |-> $past(i_reset)
    ) else $error("heap_op_decode: o_err fell without reset");

endmodule

/* hdl/heap_pkg.sv */
//########################################
// heap request package
//  heap_op_e   decoded request opcode
//  ptr_req_t   pointer port request
//  mem_req_t   memory port request
//  ram_port_t  one block ram access
//########################################

`include "heap_config.svh"

package heap_pkg;

    import word_pkg::*;

    typedef enum logic [2:0] {
        OP_IDLE       = 3'd0,
        OP_ALLOC      = 3'd1,   // top or free-list head
        OP_FREE       = 3'd2,   // push onto free-list
        OP_ALLOC_FREE = 3'd3,   // freed cell handed straight back
        OP_READ       = 3'd4,
        OP_WRITE      = 3'd5,
        OP_READ_WRITE = 3'd6,
        OP_ERROR      = 3'd7    // bad pattern or out of memory
    } heap_op_e;

    typedef struct packed {
        logic   alloc;          // alloc strobe
        logic   free;           // free strobe
        word_t  data;           // initial value of the new cell
        word_t  addr;           // cell being freed
    } ptr_req_t;

    typedef struct packed {
        logic   rd;             // read strobe
        logic   wr;             // write strobe
        word_t  raddr;
        word_t  waddr;
        word_t  wdata;
    } mem_req_t;

    typedef struct packed {
        logic                   en;
        logic [`ADDR_SZ-1:0]    addr;   // physical cell index
        word_t                  data;   // don't care on the read port
    } ram_port_t;

endpackage

/* hdl/heap_top.sv */
//########################################
// heap allocator top level
//  packs port strobes into request structs
//  request decoder, allocator
//########################################

`timescale 1ns/1ps

module heap_top
    import word_pkg::*;
    import heap_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_reset,
    input  logic    i_alloc,            // allocation request
    input  word_t   i_data,             // initial data
    input  logic    i_free,             // free request
    input  word_t   i_addr,             // address to free
    input  logic    i_wr,               // write request
    input  word_t   i_waddr,
    input  word_t   i_wdata,
    input  logic    i_rd,               // read request
    input  word_t   i_raddr,
    output word_t   o_addr,             // allocated address
    output word_t   o_rdata,            // data read
    output logic    o_err               // sticky, clears on reset
);

    ptr_req_t   ptr_req;
    mem_req_t   mem_req;
    heap_op_e   op;
    logic       exhausted;

    assign ptr_req = '{alloc: i_alloc, free: i_free, data: i_data, addr: i_addr};
    assign mem_req = '{rd: i_rd, wr: i_wr, raddr: i_raddr, waddr: i_waddr, wdata: i_wdata};

    heap_op_decode decode0 (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_ptr       (ptr_req),
        .i_mem       (mem_req),
        .i_exhausted (exhausted),
        .o_op        (op),
        .o_err       (o_err)
    );

    heap_alloc alloc0 (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_op        (op),
        .i_ptr       (ptr_req),
        .i_mem       (mem_req),
        .o_addr      (o_addr),
        .o_rdata     (o_rdata),
        .o_exhausted (exhausted)
    );

endmodule

/* hdl/word_pkg.sv */
//########################################
// tagged-word package
//  word_t      word with four type tags
//  ADDR_BASE   tag pattern of heap cells
//  reserved_e  reserved constant values
//########################################

`include "heap_config.svh"

package word_pkg;

    typedef struct packed {
        logic                   dir;    // direct fixnum / indirect ptr
        logic                   mut;    // mutable / rom
        logic                   opq;    // opaque cap / transparent ram
        logic                   vlt;    // volatile / reserved
        logic [`WORD_SZ-5:0]    field;  // payload, offset for pointers
    } word_t;

    localparam word_t ADDR_BASE = 16'h5000;     // mut + vlt, offset 0

    typedef enum logic [`WORD_SZ-1:0] {
        UNDEF = 16'h0000,                       // idle value of o_addr
        NIL   = 16'h0001,                       // empty list, ends the free-list
        TRUE  = 16'h0002,
        FALSE = 16'h0003,
        UNIT  = 16'h0004,                       // inert result
        ZERO  = 16'h8000                        // fixnum +0
    } reserved_e;

endpackage

/* run.sh */
#!/usr/bin/env bash
# build the heap testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_heap \
    && ./obj_dir/Vtb_heap | tee /dev/stderr | grep -qx "Test passed" \
    && echo "simulation ok" \
    || { echo "simulation did not pass"; exit 1; }

/* test/tb_heap_tasks.svh */
//########################################
// heap request drivers and directed tests
//  fresh cells, write/read, free-list,
//  alloc with free, halt, exhaustion
//########################################

`ifndef TB_HEAP_TASKS_SVH
`define TB_HEAP_TASKS_SVH

// drive on the rising edge; at the falling edge the outputs
// belong to the request of the previous call
task automatic drive_req(input ptr_req_t p, input mem_req_t m);
    @(posedge clk);
    ptr_req <= p;
    mem_req <= m;
    @(negedge clk);
endtask

task automatic apply_reset();
    @(posedge clk);
    reset   <= 1'b1;
    ptr_req <= '0;
    mem_req <= '0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
endtask

task automatic idle_cycle();
    drive_req('0, '0);
endtask

task automatic alloc_cell(input word_t d);
    drive_req(ptr_req_t'{alloc: 1'b1, free: 1'b0, data: d, addr: '0}, '0);
endtask

task automatic free_cell(input word_t a);
    drive_req(ptr_req_t'{alloc: 1'b0, free: 1'b1, data: '0, addr: a}, '0);
endtask

task automatic read_cell(input word_t a);
    drive_req('0, mem_req_t'{rd: 1'b1, wr: 1'b0, raddr: a, waddr: '0, wdata: '0});
endtask

task automatic write_cell(input word_t a, input word_t d);
    drive_req('0, mem_req_t'{rd: 1'b0, wr: 1'b1, raddr: '0, waddr: a, wdata: d});
endtask

task automatic fresh_allocation();
    int    errs;
    word_t d [3];
    errs = err_count;
    for (int i = 0; i < 3; i++) begin
        d[i] = rand_word();
        alloc_cell(d[i]);
        if (i > 0) begin
            check_value("fresh addr", rsp_addr, 16'(16'h5000 + i - 1));
        end
    end
    read_cell(16'h5000);
    check_value("third addr", rsp_addr, 16'h5002);
    read_cell(16'h5001);
    check_value("data at 5000", rsp_rdata, d[0]);
    read_cell(16'h5002);
    check_value("data at 5001", rsp_rdata, d[1]);
    idle_cycle();
    check_value("data at 5002", rsp_rdata, d[2]);
    check_value("addr after read", rsp_addr, UNDEF);
    end_test("fresh allocation", errs);
endtask

task automatic write_read_back();
    int    errs;
    word_t w0;
    word_t w1;
    errs = err_count;
    w0 = rand_word();
    w1 = rand_word();
    write_cell(16'h5000, w0);
    read_cell(16'h5000);                    // one cycle after the write
    check_value("addr after write", rsp_addr, UNDEF);
    drive_req('0, mem_req_t'{rd: 1'b1, wr: 1'b1, raddr: 16'h5000,
                             waddr: 16'h5001, wdata: w1});
    check_value("read back", rsp_rdata, w0);
    read_cell(16'h5001);
    check_value("read beside write", rsp_rdata, w0);
    idle_cycle();
    check_value("written in read cycle", rsp_rdata, w1);
    check_value("addr idle", rsp_addr, UNDEF);
    end_test("write and read", errs);
endtask

task automatic lifo_free_list();
    int    errs;
    word_t d;
    errs = err_count;
    d = rand_word();
    free_cell(16'h5001);
    free_cell(16'h5002);
    alloc_cell(d);
    read_cell(16'h5002);                    // ram port taken while link pending
    check_value("first pop", rsp_addr, 16'h5002);
    alloc_cell(rand_word());
    check_value("popped cell data", rsp_rdata, d);
    alloc_cell(rand_word());
    check_value("second pop", rsp_addr, 16'h5001);
    free_cell(16'h5002);
    check_value("top after empty list", rsp_addr, 16'h5003);
    free_cell(16'h5001);
    alloc_cell(rand_word());                // three allocs back to back
    alloc_cell(rand_word());
    check_value("back to back pop 1", rsp_addr, 16'h5001);
    alloc_cell(rand_word());
    check_value("back to back pop 2", rsp_addr, 16'h5002);
    idle_cycle();
    check_value("back to back top", rsp_addr, 16'h5004);
    end_test("lifo free-list", errs);
endtask

task automatic alloc_with_free();
    int    errs;
    word_t d;
    errs = err_count;
    d = rand_word();
    drive_req(ptr_req_t'{alloc: 1'b1, free: 1'b1, data: d, addr: 16'h5003}, '0);
    alloc_cell(rand_word());
    check_value("recycled addr", rsp_addr, 16'h5003);
    read_cell(16'h5003);
    check_value("top after recycle", rsp_addr, 16'h5005);
    free_cell(16'h5001);
    check_value("recycled data", rsp_rdata, d);
    drive_req(ptr_req_t'{alloc: 1'b1, free: 1'b1, data: d, addr: 16'h5002}, '0);
    alloc_cell(rand_word());
    check_value("recycled with list", rsp_addr, 16'h5002);
    idle_cycle();
    check_value("head kept", rsp_addr, 16'h5001);
    end_test("alloc with free", errs);
endtask

task automatic error_halt();
    int errs;
    errs = err_count;
    drive_req(ptr_req_t'{alloc: 1'b1, free: 1'b0, data: rand_word(), addr: '0},
              mem_req_t'{rd: 1'b1, wr: 1'b0, raddr: 16'h5000, waddr: '0, wdata: '0});
    check_value("err before fault", rsp_err, 1'b0);
    alloc_cell(rand_word());
    check_value("err raised", rsp_err, 1'b1);
    check_value("faulty alloc addr", rsp_addr, UNDEF);
    idle_cycle();
    check_value("halted alloc addr", rsp_addr, UNDEF);
    check_value("err held", rsp_err, 1'b1);
    apply_reset();
    check_value("err after reset", rsp_err, 1'b0);
    alloc_cell(rand_word());
    idle_cycle();
    check_value("first addr after reset", rsp_addr, 16'h5000);
    end_test("error and halt", errs);
endtask

task automatic exhaustion();
    int errs;
    errs = err_count;
    apply_reset();
    for (int i = 0; i < 255; i++) begin
        alloc_cell(rand_word());
        if (i > 0) begin
            check_value("fresh addr", rsp_addr, 16'(16'h5000 + i - 1));
        end
    end
    alloc_cell(rand_word());                // no fresh cell left
    check_value("last cell", rsp_addr, 16'h50FE);
    check_value("err before overrun", rsp_err, 1'b0);
    idle_cycle();
    check_value("err on overrun", rsp_err, 1'b1);
    check_value("overrun addr", rsp_addr, UNDEF);
    end_test("exhaustion", errs);
endtask

`endif

/* test/tb_heap.sv */
//########################################
// heap allocator testbench
//  clock, reset, dut0, run limit
//  request drivers, value check
//  directed test sequence
//########################################

`timescale 1ns/1ps

module tb_heap
    import word_pkg::*;
    import heap_pkg::*;
();

    localparam int CYCLE_LIMIT = 700;       // exhaustion ~260, rest ~70, then margin
    localparam int SEED        = 50163;

    logic       clk;
    logic       reset;
    ptr_req_t   ptr_req;                    // pointer port strobes and words
    mem_req_t   mem_req;                    // memory port strobes and words
    word_t      rsp_addr;
    word_t      rsp_rdata;
    logic       rsp_err;
    int         cycle_count;
    int         err_count;                  // mismatches over the whole run
    int         test_count;
    int         bad_tests;

    always #10 clk = ~clk;                  // 20 ns period

    heap_top dut0 (
        .i_clk   (clk),
        .i_reset (reset),
        .i_alloc (ptr_req.alloc),
        .i_data  (ptr_req.data),
        .i_free  (ptr_req.free),
        .i_addr  (ptr_req.addr),
        .i_wr    (mem_req.wr),
        .i_waddr (mem_req.waddr),
        .i_wdata (mem_req.wdata),
        .i_rd    (mem_req.rd),
        .i_raddr (mem_req.raddr),
        .o_addr  (rsp_addr),
        .o_rdata (rsp_rdata),
        .o_err   (rsp_err)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: tests still running after %0d cycles", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    function automatic word_t rand_word();
        logic [31:0] r;
        r = $urandom;
        return word_t'(r[15:0]);            // any tag pattern is fine as data
    endfunction

    task automatic check_value(input string what, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp) begin
            err_count++;
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    function automatic void end_test(input string name, input int errs_before);
        test_count++;
        if (err_count == errs_before) begin
            $display("%s: ok", name);
        end else begin
            bad_tests++;
            $display("%s: %0d mismatches", name, err_count - errs_before);
        end
    endfunction

    `include "tb_heap_tasks.svh"

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;                 // held until the first reset pulse
        ptr_req     = '0;
        mem_req     = '0;
        cycle_count = 0;
        err_count   = 0;
        test_count  = 0;
        bad_tests   = 0;
        void'($urandom(SEED));
        apply_reset();
        fresh_allocation();
        write_read_back();
        lifo_free_list();
        alloc_with_free();
        error_halt();
        exhaustion();
        $display("tests %0d, failing %0d, mismatches %0d", test_count, bad_tests, err_count);
        if (err_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+hdl
+incdir+test
hdl/word_pkg.sv
hdl/heap_pkg.sv
hdl/heap_bram.sv
hdl/heap_op_decode.sv
hdl/heap_alloc.sv
hdl/heap_top.sv
test/tb_heap.sv
